//--- rv_isa_pkg.sv
package rv_isa_pkg;

  // data word, used for registers, pc, immediates and instructions
  typedef logic [31:0] word_t;

  // architectural register index
  typedef logic [4:0] reg_idx_t;

  // shift amount taken from an operand
  typedef logic [4:0] shamt_t;

  // instruction fields
  typedef logic [6:0] opcode_t;
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // major opcodes
  localparam opcode_t OP_LUI     = 7'b01_101_11;
  localparam opcode_t OP_REG_IMM = 7'b00_100_11;
  localparam opcode_t OP_REG_REG = 7'b01_100_11;
  localparam opcode_t OP_BRANCH  = 7'b11_000_11;
  localparam opcode_t OP_ENVIRON = 7'b11_100_11;

  // funct7 values for the integer groups
  localparam funct7_t FUNCT7_BASE = 7'b000_0000;
  // selects SUB, SRA and SRAI
  localparam funct7_t FUNCT7_ALT  = 7'b010_0000;

  // alu funct3, shared by register-immediate and register-register
  localparam funct3_t F3_ADD_SUB = 3'b000;
  localparam funct3_t F3_SLL     = 3'b001;
  localparam funct3_t F3_SLT     = 3'b010;
  localparam funct3_t F3_SLTU    = 3'b011;
  localparam funct3_t F3_XOR     = 3'b100;
  localparam funct3_t F3_SRL_SRA = 3'b101;
  localparam funct3_t F3_OR      = 3'b110;
  localparam funct3_t F3_AND     = 3'b111;

  // branch funct3
  localparam funct3_t F3_BEQ  = 3'b000;
  localparam funct3_t F3_BNE  = 3'b001;
  localparam funct3_t F3_BLT  = 3'b100;
  localparam funct3_t F3_BGE  = 3'b101;
  localparam funct3_t F3_BLTU = 3'b110;
  localparam funct3_t F3_BGEU = 3'b111;

endpackage

//--- core_cfg_pkg.sv
package core_cfg_pkg;

  // operations the alu can perform
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    // second operand straight through, for lui
    ALU_PASS_B
  } alu_op_t;

  // start address after reset
  localparam rv_isa_pkg::word_t DEFAULT_RESET_PC = 32'h0000_0000;

  // full rv32i register count
  localparam int DEFAULT_NUM_REGS = 32;

endpackage

//--- decode_if.sv
`timescale 1ns/1ps

interface decode_if
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
();

  // register indices
  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;

  // immediate for the current format, operand select and operation
  word_t    imm;
  logic     use_imm;
  alu_op_t  alu_op;

  // control levels for the current instruction
  logic     reg_we;
  logic     branch;
  funct3_t  funct3;
  logic     halt;

  modport dec (
    output rs1, rs2, rd, imm, use_imm, alu_op, reg_we, branch, funct3, halt
  );

  // execution side only needs operands and control
  modport exe (
    input imm, use_imm, alu_op, branch, funct3, halt
  );

endinterface

//--- rv_decoder.sv
`timescale 1ns/1ps

module rv_decoder
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
(
  input word_t  insn,
  decode_if.dec dec
);

  opcode_t opcode;
  funct3_t funct3;
  funct7_t funct7;

  word_t imm_i;
  word_t imm_b;
  word_t imm_u;

  logic alt;
  logic imm_alt;
  logic imm_ok;
  logic reg_ok;
  logic branch_ok;
  logic is_ecall;

  // same funct3 mapping for both integer groups
  function automatic alu_op_t alu_op_of(funct3_t f3, logic sel_alt);
    alu_op_t op;
    case (f3)
      F3_ADD_SUB: op = sel_alt ? ALU_SUB : ALU_ADD;
      F3_SLL:     op = ALU_SLL;
      F3_SLT:     op = ALU_SLT;
      F3_SLTU:    op = ALU_SLTU;
      F3_XOR:     op = ALU_XOR;
      F3_SRL_SRA: op = sel_alt ? ALU_SRA : ALU_SRL;
      F3_OR:      op = ALU_OR;
      default:    op = ALU_AND;
    endcase
    return op;
  endfunction

  // field split
  assign opcode = insn[6:0];
  assign funct3 = insn[14:12];
  assign funct7 = insn[31:25];

  assign dec.rd     = insn[11:7];
  assign dec.rs1    = insn[19:15];
  assign dec.rs2    = insn[24:20];
  assign dec.funct3 = funct3;

  // sign-extended immediates
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};

  assign alt = (funct7 == FUNCT7_ALT);

  // for immediates the upper bits only mean funct7 on shifts
  assign imm_alt = alt && (funct3 == F3_SRL_SRA);

  assign imm_ok = (funct3 == F3_SLL)     ? (funct7 == FUNCT7_BASE) :
                  (funct3 == F3_SRL_SRA) ? (funct7 == FUNCT7_BASE || alt) :
                  1'b1;

  // alt funct7 only exists for SUB and SRA
  assign reg_ok = (funct7 == FUNCT7_BASE) ||
                  (alt && (funct3 == F3_ADD_SUB || funct3 == F3_SRL_SRA));

  assign branch_ok = funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU};

  // ecall has every field above the opcode at zero
  assign is_ecall = (insn[31:7] == '0);

  always_comb
  begin
    dec.imm     = imm_i;
    dec.use_imm = 1'b0;
    dec.alu_op  = ALU_ADD;
    dec.reg_we  = 1'b0;
    dec.branch  = 1'b0;
    dec.halt    = 1'b0;

    case (opcode)
      OP_LUI:
      begin
        dec.imm     = imm_u;
        dec.use_imm = 1'b1;
        dec.alu_op  = ALU_PASS_B;
        dec.reg_we  = 1'b1;
      end
      OP_REG_IMM:
      begin
        dec.use_imm = 1'b1;
        dec.alu_op  = alu_op_of(funct3, imm_alt);
        dec.reg_we  = imm_ok;
      end
      OP_REG_REG:
      begin
        dec.alu_op = alu_op_of(funct3, alt);
        dec.reg_we = reg_ok;
      end
      OP_BRANCH:
      begin
        dec.imm    = imm_b;
        dec.branch = branch_ok;
      end
      OP_ENVIRON:
      begin
        dec.halt = is_ecall;
      end
      default:
      begin
        // unknown opcode, no write and pc + 4
        dec.reg_we = 1'b0;
      end
    endcase
  end

endmodule

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
#(
  parameter int NUM_REGS = DEFAULT_NUM_REGS
) (
  input  logic     clk,
  input  logic     rst,
  input  logic     we,
  input  reg_idx_t rd,
  input  word_t    rd_data,
  input  reg_idx_t rs1,
  output word_t    rs1_data,
  input  reg_idx_t rs2,
  output word_t    rs2_data
);

  word_t regs [NUM_REGS];

  logic wr_ok;
  logic rs1_ok;
  logic rs2_ok;

  // x0 and indices past the array are not backed by storage
  assign wr_ok  = we && (rd != '0) && (int'(rd) < NUM_REGS);
  assign rs1_ok = (rs1 != '0) && (int'(rs1) < NUM_REGS);
  assign rs2_ok = (rs2 != '0) && (int'(rs2) < NUM_REGS);

  assign rs1_data = rs1_ok ? regs[rs1] : '0;
  assign rs2_data = rs2_ok ? regs[rs2] : '0;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      for (int i = 0; i < NUM_REGS; i++)
      begin
        regs[i] <= '0;
      end
    end
    else if (wr_ok)
    begin
      regs[rd] <= rd_data;
    end
  end

endmodule

//--- alu.sv
`timescale 1ns/1ps

module alu
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
(
  decode_if.exe dec,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output word_t result
);

  word_t  op_b;
  shamt_t shamt;

  // immediate for lui and the register-immediate group
  assign op_b  = dec.use_imm ? dec.imm : rs2_data;

  // only the low five bits shift
  assign shamt = op_b[4:0];

  always_comb
  begin
    case (dec.alu_op)
      ALU_ADD:
      begin
        result = rs1_data + op_b;
      end
      ALU_SUB:
      begin
        result = rs1_data - op_b;
      end
      ALU_SLT:
      begin
        result = word_t'($signed(rs1_data) < $signed(op_b));
      end
      ALU_SLTU:
      begin
        result = word_t'(rs1_data < op_b);
      end
      ALU_XOR:
      begin
        result = rs1_data ^ op_b;
      end
      ALU_OR:
      begin
        result = rs1_data | op_b;
      end
      ALU_AND:
      begin
        result = rs1_data & op_b;
      end
      ALU_SLL:
      begin
        result = rs1_data << shamt;
      end
      ALU_SRL:
      begin
        result = rs1_data >> shamt;
      end
      ALU_SRA:
      begin
        // sign bit fills from the left
        result = word_t'($signed(rs1_data) >>> shamt);
      end
      default:
      begin
        result = op_b;
      end
    endcase
  end

endmodule

//--- pc_unit.sv
`timescale 1ns/1ps

module pc_unit
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
#(
  parameter word_t RESET_PC = DEFAULT_RESET_PC
) (
  input  logic  clk,
  input  logic  rst,
  decode_if.exe dec,
  input  word_t rs1_data,
  input  word_t rs2_data,
  output word_t pc
);

  logic  taken;
  word_t pc_next;

  // branch condition from funct3
  always_comb
  begin
    taken = 1'b0;
    if (dec.branch)
    begin
      case (dec.funct3)
        F3_BEQ:  taken = (rs1_data == rs2_data);
        F3_BNE:  taken = (rs1_data != rs2_data);
        F3_BLT:  taken = ($signed(rs1_data) < $signed(rs2_data));
        F3_BGE:  taken = ($signed(rs1_data) >= $signed(rs2_data));
        F3_BLTU: taken = (rs1_data < rs2_data);
        F3_BGEU: taken = (rs1_data >= rs2_data);
        default: taken = 1'b0;
      endcase
    end
  end

  always_comb
  begin
    if (dec.halt)
    begin
      // ecall parks the core on itself
      pc_next = pc;
    end
    else if (taken)
    begin
      pc_next = pc + dec.imm;
    end
    else
    begin
      pc_next = pc + 32'd4;
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      pc <= RESET_PC;
    end
    else
    begin
      pc <= pc_next;
    end
  end

endmodule

//--- rv_core.sv
`timescale 1ns/1ps

module rv_core
  import rv_isa_pkg::*;
  import core_cfg_pkg::*;
#(
  parameter word_t RESET_PC = DEFAULT_RESET_PC,
  parameter int    NUM_REGS = DEFAULT_NUM_REGS
) (
  input  logic     clk,
  input  logic     rst,
  input  word_t    insn,
  output word_t    pc,
  output logic     halt,
  output logic     wb_we,
  output reg_idx_t wb_rd,
  output word_t    wb_data
);

  word_t rs1_data;
  word_t rs2_data;

  decode_if dec_bus ();

  rv_decoder u_decoder (
    .insn (insn),
    .dec  (dec_bus)
  );

  // the register write bus doubles as the writeback trace
  reg_file #(
    .NUM_REGS (NUM_REGS)
  ) u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we       (wb_we),
    .rd       (wb_rd),
    .rd_data  (wb_data),
    .rs1      (dec_bus.rs1),
    .rs1_data (rs1_data),
    .rs2      (dec_bus.rs2),
    .rs2_data (rs2_data)
  );

  alu u_alu (
    .dec      (dec_bus),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .result   (wb_data)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc_unit (
    .clk      (clk),
    .rst      (rst),
    .dec      (dec_bus),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .pc       (pc)
  );

  // no register write while reset is held
  assign wb_we = dec_bus.reg_we & ~rst;
  assign wb_rd = dec_bus.rd;
  assign halt  = dec_bus.halt;

endmodule

//--- tb_rv_tasks.svh
// instruction encoders
function automatic word_t lui_insn(reg_idx_t rd, logic [19:0] imm);
  return {imm, rd, 7'b0110111};
endfunction

function automatic word_t imm_insn(logic [2:0] f3, reg_idx_t rd, reg_idx_t rs1, logic [11:0] imm);
  return {imm, rs1, f3, rd, 7'b0010011};
endfunction

function automatic word_t shift_insn(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                     reg_idx_t rs1, logic [4:0] sh);
  return {f7, sh, rs1, f3, rd, 7'b0010011};
endfunction

function automatic word_t reg_insn(logic [6:0] f7, logic [2:0] f3, reg_idx_t rd,
                                   reg_idx_t rs1, reg_idx_t rs2);
  return {f7, rs2, rs1, f3, rd, 7'b0110011};
endfunction

function automatic word_t branch_insn(logic [2:0] f3, reg_idx_t rs1, reg_idx_t rs2, int off);
  logic [12:0] o;
  o = off[12:0];
  return {o[12], o[10:5], rs2, rs1, f3, o[4:1], o[11], 7'b1100011};
endfunction

// signed less-than from the sign bits and the unsigned compare
function automatic logic slt_ref(word_t a, word_t b);
  return (a[31] != b[31]) ? a[31] : (a < b);
endfunction

function automatic word_t alu_ref(logic [2:0] f3, logic alt, word_t a, word_t b);
  logic [63:0] ext;
  ext = {{32{a[31]}}, a} >> b[4:0];
  case (f3)
    3'd0: return alt ? a - b : a + b;
    3'd1: return a << b[4:0];
    3'd2: return word_t'(slt_ref(a, b));
    3'd3: return word_t'(a < b);
    3'd4: return a ^ b;
    3'd5: return alt ? ext[31:0] : a >> b[4:0];
    3'd6: return a | b;
    default: return a & b;
  endcase
endfunction

// expected effect of one instruction on the reference state
task automatic model_insn(input word_t i, output logic we, output reg_idx_t rd,
                          output word_t data, output logic hlt, output word_t npc);
  word_t       a;
  word_t       b;
  word_t       imm_b;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        cond;
  a = ref_regs[i[19:15]];
  b = ref_regs[i[24:20]];
  f3 = i[14:12];
  f7 = i[31:25];
  rd = i[11:7];
  imm_b = {{19{i[31]}}, i[31], i[7], i[30:25], i[11:8], 1'b0};
  we = 1'b0;
  data = '0;
  hlt = 1'b0;
  npc = exp_pc + 32'd4;
  case (i[6:0])
    7'b0110111:
    begin
      we = 1'b1;
      data = {i[31:12], 12'h000};
    end
    7'b0010011:
    begin
      // funct7 only constrains the shift forms
      we = (f3 == 3'd1) ? (f7 == 7'h00) :
           (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
      data = alu_ref(f3, f3 == 3'd5 && f7 == 7'h20, a, {{20{i[31]}}, i[31:20]});
    end
    7'b0110011:
    begin
      we = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      data = alu_ref(f3, f7 == 7'h20, a, b);
    end
    7'b1100011:
    begin
      case (f3)
        3'd0: cond = (a == b);
        3'd1: cond = (a != b);
        3'd4: cond = slt_ref(a, b);
        3'd5: cond = !slt_ref(a, b);
        3'd6: cond = (a < b);
        3'd7: cond = (a >= b);
        default: cond = 1'b0;
      endcase
      if (cond)
        npc = exp_pc + imm_b;
    end
    7'b1110011:
    begin
      if (i[31:7] == '0)
      begin
        hlt = 1'b1;
        npc = exp_pc;
      end
    end
    default:
    begin
      we = 1'b0;
    end
  endcase
endtask

// unused words hold an unknown opcode that carries the address
task automatic clear_program();
  for (int k = 0; k < IMEM_WORDS; k++)
    imem[k] = word_t'(k) << 7;
  prog_len = 0;
endtask

task automatic emit(word_t w);
  check_true(prog_len < IMEM_WORDS, "program does not fit in instruction memory");
  imem[prog_len] = w;
  prog_len++;
endtask

task automatic load_const(reg_idx_t rd, word_t v);
  word_t up;
  up = (v + 32'h800) >> 12;
  emit(lui_insn(rd, up[19:0]));
  emit(imm_insn(3'd0, rd, rd, v[11:0]));
endtask

task automatic reset_core();
  @(posedge clk);
  rst <= 1'b1;
  for (int k = 0; k < RST_CYCLES; k++)
  begin
    @(negedge clk);
    check_word("wb_we", 32'd0, word_t'(wb_we));
    if (k > 0)
      check_word("pc", RESET_PC, pc);
  end
  @(posedge clk);
  rst <= 1'b0;
  foreach (ref_regs[r])
    ref_regs[r] = '0;
  exp_pc = RESET_PC;
endtask

task automatic step_and_check();
  word_t    i;
  logic     we;
  reg_idx_t rd;
  word_t    data;
  logic     hlt;
  word_t    npc;
  @(negedge clk);
  check_word("pc", exp_pc, pc);
  i = imem[exp_pc[8:2]];
  model_insn(i, we, rd, data, hlt, npc);
  check_word("halt", word_t'(hlt), word_t'(halt));
  check_word("wb_we", word_t'(we), word_t'(wb_we));
  if (we)
  begin
    check_word("wb_rd", word_t'(rd), word_t'(wb_rd));
    check_word("wb_data", data, wb_data);
    if (rd != 0)
      ref_regs[rd] = data;
  end
  exp_pc = npc;
endtask

task automatic run_steps(int n);
  repeat (n)
    step_and_check();
endtask

// runs until the pc walks off the end of the program
task automatic run_program();
  int steps;
  steps = 0;
  reset_core();
  while (exp_pc != word_t'(prog_len * 4))
  begin
    check_true(steps < MAX_STEPS, "program did not reach its last instruction");
    step_and_check();
    steps++;
  end
endtask

task automatic lui_addi_test();
  clear_program();
  emit(lui_insn(1, 20'h12345));
  emit(imm_insn(3'd0, 2, 1, 12'h678));
  emit(imm_insn(3'd0, 3, 0, 12'hfff));
  emit(imm_insn(3'd0, 4, 1, 12'h800));
  emit(imm_insn(3'd0, 5, 3, 12'd100));
  emit(lui_insn(6, 20'hfffff));
  run_program();
endtask

task automatic reg_ops_test();
  word_t a;
  word_t b;
  clear_program();
  for (int r = 0; r < 2; r++)
  begin
    a = $urandom();
    b = $urandom();
    // first round with operands of opposite sign
    if (r == 0)
    begin
      a[31] = 1'b1;
      b[31] = 1'b0;
    end
    load_const(1, a);
    load_const(2, b);
    for (int f = 0; f < 8; f++)
      emit(reg_insn(7'h00, f[2:0], reg_idx_t'(3 + f), 1, 2));
    emit(reg_insn(7'h20, 3'd0, 11, 1, 2));
    emit(reg_insn(7'h20, 3'd5, 12, 1, 2));
    emit(reg_insn(7'h00, 3'd2, 13, 2, 1));
    emit(reg_insn(7'h00, 3'd3, 14, 2, 1));
  end
  // most negative minus one wraps
  emit(lui_insn(5, 20'h80000));
  emit(imm_insn(3'd0, 6, 0, 12'h001));
  emit(reg_insn(7'h20, 3'd0, 7, 5, 6));
  run_program();
endtask

task automatic shifts_test();
  word_t      a;
  word_t      s;
  logic [4:0] sh;
  clear_program();
  a = $urandom() | 32'h8000_0000;
  s = $urandom() | 32'h0000_0100;
  sh = 5'($urandom_range(31, 1));
  load_const(1, a);
  load_const(2, s);
  load_const(3, a >> 1);
  emit(shift_insn(7'h00, 3'd1, 4, 1, sh));
  emit(shift_insn(7'h00, 3'd5, 5, 1, sh));
  emit(shift_insn(7'h20, 3'd5, 6, 1, sh));
  emit(shift_insn(7'h20, 3'd5, 7, 3, sh));
  emit(shift_insn(7'h20, 3'd5, 8, 1, 5'd31));
  emit(reg_insn(7'h00, 3'd1, 9, 1, 2));
  emit(reg_insn(7'h00, 3'd5, 10, 1, 2));
  emit(reg_insn(7'h20, 3'd5, 11, 1, 2));
  emit(reg_insn(7'h20, 3'd5, 12, 3, 2));
  run_program();
endtask

task automatic branches_test();
  logic [2:0] b3 [6] = '{3'd0, 3'd1, 3'd4, 3'd5, 3'd6, 3'd7};
  reg_idx_t   ra [3] = '{5'd1, 5'd2, 5'd2};
  reg_idx_t   rb [3] = '{5'd2, 5'd1, 5'd3};
  clear_program();
  // x1 is negative, x2 and x3 are equal
  emit(imm_insn(3'd0, 1, 0, 12'hffb));
  emit(imm_insn(3'd0, 2, 0, 12'd7));
  emit(imm_insn(3'd0, 3, 0, 12'd7));
  foreach (b3[f])
  begin
    for (int p = 0; p < 3; p++)
    begin
      emit(branch_insn(b3[f], ra[p], rb[p], 8));
      emit(imm_insn(3'd0, 9, 9, 12'd1));
      // hop over a landing slot, then branch back into it
      emit(branch_insn(3'd0, 0, 0, 12));
      emit(imm_insn(3'd0, 10, 10, 12'd1));
      emit(branch_insn(3'd0, 0, 0, 8));
      emit(branch_insn(b3[f], ra[p], rb[p], -8));
    end
  end
  run_program();
endtask

task automatic x0_deps_test();
  clear_program();
  emit(imm_insn(3'd0, 0, 0, 12'd123));
  emit(reg_insn(7'h00, 3'd0, 1, 0, 0));
  emit(imm_insn(3'd0, 2, 0, 12'd5));
  emit(reg_insn(7'h00, 3'd0, 3, 2, 2));
  emit(reg_insn(7'h20, 3'd0, 4, 3, 2));
  emit(reg_insn(7'h00, 3'd4, 5, 4, 3));
  emit(lui_insn(0, 20'habcde));
  emit(reg_insn(7'h00, 3'd0, 6, 0, 2));
  // multiply encoding, not decoded here
  emit(reg_insn(7'h01, 3'd0, 7, 2, 2));
  emit(reg_insn(7'h00, 3'd0, 8, 7, 5));
  run_program();
endtask

task automatic ecall_halt_test();
  clear_program();
  emit(imm_insn(3'd0, 1, 0, 12'd1));
  emit(imm_insn(3'd0, 1, 1, 12'd1));
  emit(32'h0000_0073);
  emit(imm_insn(3'd0, 2, 0, 12'd3));
  reset_core();
  run_steps(2 + 5);
  // core parked on the ecall at word 2
  check_word("pc", 32'd8, pc);
  check_word("halt", 32'd1, word_t'(halt));
  reset_core();
  run_steps(1);
endtask

//--- tb_rv_core.sv
`timescale 1ns/1ps

module tb_rv_core
  import rv_isa_pkg::*;
;

  localparam int    CLK_PERIOD = 10;
  localparam int    RST_CYCLES = 5;
  localparam int    IMEM_WORDS = 128;
  localparam int    MAX_STEPS  = 2 * IMEM_WORDS;
  localparam int    NUM_TESTS  = 6;
  localparam word_t RESET_PC   = 32'h0000_0000;

  // worst case of every test running to its step limit, plus margin
  localparam int TEST_CYCLES = NUM_TESTS * (2 * (RST_CYCLES + 2) + MAX_STEPS);
  localparam int TIMEOUT_NS  = TEST_CYCLES * CLK_PERIOD + 1000;

  logic     clk;
  logic     rst;
  word_t    insn;
  word_t    pc;
  logic     halt;
  logic     wb_we;
  reg_idx_t wb_rd;
  word_t    wb_data;

  // instruction memory and reference state
  word_t imem [IMEM_WORDS];
  int    prog_len;
  word_t ref_regs [32];
  word_t exp_pc;

  rv_core #(
    .RESET_PC (RESET_PC),
    .NUM_REGS (32)
  ) DUT (
    .clk     (clk),
    .rst     (rst),
    .insn    (insn),
    .pc      (pc),
    .halt    (halt),
    .wb_we   (wb_we),
    .wb_rd   (wb_rd),
    .wb_data (wb_data)
  );

  // combinational fetch
  assign insn = imem[pc[8:2]];

  initial
  begin
    clk = 1'b0;
    forever
    begin
      #(CLK_PERIOD / 2) clk = ~clk;
    end
  end

  task automatic check_word(string name, word_t exp, word_t act);
    assert (act === exp)
    else
    begin
      $display("ERROR at %0t ns: %s expected 0x%08h, got 0x%08h", $time, name, exp, act);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  task automatic check_true(logic cond, string what);
    assert (cond)
    else
    begin
      $display("at %0t ns: %s", $time, what);
      $display("Test FAILED");
      $fatal(1);
    end
  endtask

  `include "tb_rv_tasks.svh"

  initial
  begin
    #(TIMEOUT_NS);
    $display("timeout after %0d ns, the tests did not finish", TIMEOUT_NS);
    $display("Test FAILED");
    $fatal(1);
  end

  initial
  begin
    void'($urandom(21574));
    rst = 1'b1;
    exp_pc = RESET_PC;
    clear_program();
    lui_addi_test();
    reg_ops_test();
    shifts_test();
    branches_test();
    x0_deps_test();
    ecall_halt_test();
    $display("Test OK");
    $finish;
  end

endmodule

//--- sim.f
+incdir+.
rv_isa_pkg.sv
core_cfg_pkg.sv
decode_if.sv
rv_decoder.sv
reg_file.sv
alu.sv
pc_unit.sv
rv_core.sv
tb_rv_core.sv

//--- Bender.yml
package:
  name: rv_core

sources:
  - files:
      - rv_isa_pkg.sv
      - core_cfg_pkg.sv
      - decode_if.sv
      - rv_decoder.sv
      - reg_file.sv
      - alu.sv
      - pc_unit.sv
      - rv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
